// ==== logic/lbp_pkg.sv ====
`default_nettype none

package lbp_pkg;

  // frame geometry for this build
  localparam int IMG_COLS = 16;
  localparam int IMG_ROWS = 16;
  localparam int FRAME_PIX = IMG_COLS * IMG_ROWS;
  localparam int COL_W = $clog2(IMG_COLS);
  localparam int ROW_W = $clog2(IMG_ROWS);
  localparam int PIX_CNT_W = $clog2(FRAME_PIX);

  localparam int PIX_W = 8;
  localparam int CODE_W = 8;
  localparam int CNT_W = 16;

  // nine 8-bit pixels need 12 bits
  localparam int SUM_W = 12;

  // one bank of 2**CODE_W bins per descriptor
  localparam int BIN_W = CODE_W + 1;
  localparam int NUM_BINS = 1 << BIN_W;

  // last valid_i to frame_done_o
  localparam int DONE_DLY = 5;

  typedef struct packed {
    logic [PIX_W-1:0] nw;
    logic [PIX_W-1:0] n;
    logic [PIX_W-1:0] ne;
    logic [PIX_W-1:0] w;
    logic [PIX_W-1:0] c;
    logic [PIX_W-1:0] e;
    logic [PIX_W-1:0] sw;
    logic [PIX_W-1:0] s;
    logic [PIX_W-1:0] se;
  } window_t;

  typedef struct packed {
    logic              valid;
    logic [CODE_W-1:0] code;
  } code_req_t;

  typedef enum logic {
    DESC_NI  = 1'b0,
    DESC_LBP = 1'b1
  } desc_e;

  // neighbours indexed by code bit
  typedef logic [CODE_W-1:0][PIX_W-1:0] nbr_t;

  // bit order e, ne, n, nw, w, sw, s, se
  function automatic nbr_t window_nbrs(window_t win);
    nbr_t nbrs;
    nbrs[0] = win.e;
    nbrs[1] = win.ne;
    nbrs[2] = win.n;
    nbrs[3] = win.nw;
    nbrs[4] = win.w;
    nbrs[5] = win.sw;
    nbrs[6] = win.s;
    nbrs[7] = win.se;
    return nbrs;
  endfunction

endpackage

`default_nettype wire

// ==== logic/line_window_3x3.sv ====
`default_nettype none

module line_window_3x3 (
  input  logic                      clk,
  input  logic                      arst_n_i,
  input  logic                      valid_i,
  input  logic [lbp_pkg::PIX_W-1:0] pixel_i,
  output logic                      win_valid_o,
  output lbp_pkg::window_t          win_o
);

  logic [lbp_pkg::COL_W-1:0] col_q;
  logic [lbp_pkg::ROW_W-1:0] row_q;
  logic                      col_last;
  logic                      row_last;
  logic                      interior;

  // row buffers, one and two rows back
  logic [lbp_pkg::PIX_W-1:0] row1_mem [lbp_pkg::IMG_COLS];
  logic [lbp_pkg::PIX_W-1:0] row2_mem [lbp_pkg::IMG_COLS];

  // column stages, index 0 is the newest column
  logic [lbp_pkg::PIX_W-1:0] top_q [3];
  logic [lbp_pkg::PIX_W-1:0] mid_q [3];
  logic [lbp_pkg::PIX_W-1:0] bot_q [3];

  assign col_last = (col_q == lbp_pkg::COL_W'(lbp_pkg::IMG_COLS - 1));
  assign row_last = (row_q == lbp_pkg::ROW_W'(lbp_pkg::IMG_ROWS - 1));
  assign interior = (row_q >= lbp_pkg::ROW_W'(2)) && (col_q >= lbp_pkg::COL_W'(2));

  // raster position of the incoming pixel
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      col_q <= '0;
      row_q <= '0;
      win_valid_o <= 1'b0;
    end else begin
      win_valid_o <= valid_i && interior;
      if (valid_i) begin
        if (col_last) begin
          col_q <= '0;
          row_q <= row_last ? '0 : row_q + 1'b1;
        end else begin
          col_q <= col_q + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (valid_i) begin
      row2_mem[col_q] <= row1_mem[col_q];
      row1_mem[col_q] <= pixel_i;
      top_q[0] <= row2_mem[col_q];
      mid_q[0] <= row1_mem[col_q];
      bot_q[0] <= pixel_i;
      for (int i = 1; i < 3; i++) begin
        top_q[i] <= top_q[i-1];
        mid_q[i] <= mid_q[i-1];
        bot_q[i] <= bot_q[i-1];
      end
    end
  end

  // oldest column is west, top row is north
  always_comb begin
    win_o.nw = top_q[2];
    win_o.n  = top_q[1];
    win_o.ne = top_q[0];
    win_o.w  = mid_q[2];
    win_o.c  = mid_q[1];
    win_o.e  = mid_q[0];
    win_o.sw = bot_q[2];
    win_o.s  = bot_q[1];
    win_o.se = bot_q[0];
  end

endmodule

`default_nettype wire

// ==== logic/ni_code.sv ====
`default_nettype none

module ni_code (
  input  logic               clk,
  input  logic               arst_n_i,
  input  logic               win_valid_i,
  input  lbp_pkg::window_t   win_i,
  output lbp_pkg::code_req_t req_o
);

  lbp_pkg::nbr_t              nbrs;
  logic [lbp_pkg::SUM_W-1:0]  win_sum;
  logic [lbp_pkg::SUM_W-1:0]  nine_x [lbp_pkg::CODE_W];
  logic [lbp_pkg::CODE_W-1:0] code_d;
  logic [lbp_pkg::CODE_W-1:0] code_q;
  logic                       valid_q;

  assign nbrs = lbp_pkg::window_nbrs(win_i);

  // sum of all nine pixels, centre included
  always_comb begin
    win_sum = lbp_pkg::SUM_W'(win_i.c);
    for (int i = 0; i < lbp_pkg::CODE_W; i++) begin
      win_sum = win_sum + lbp_pkg::SUM_W'(nbrs[i]);
    end
  end

  // 9*nb >= sum is the same test as nb >= mean
  always_comb begin
    for (int i = 0; i < lbp_pkg::CODE_W; i++) begin
      nine_x[i] = (lbp_pkg::SUM_W'(nbrs[i]) << 3) + lbp_pkg::SUM_W'(nbrs[i]);
      code_d[i] = (nine_x[i] >= win_sum);
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= win_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (win_valid_i) begin
      code_q <= code_d;
    end
  end

  assign req_o = '{valid: valid_q, code: code_q};

endmodule

`default_nettype wire

// ==== logic/lbp_code.sv ====
`default_nettype none

module lbp_code (
  input  logic               clk,
  input  logic               arst_n_i,
  input  logic               win_valid_i,
  input  lbp_pkg::window_t   win_i,
  output lbp_pkg::code_req_t req_o
);

  lbp_pkg::nbr_t              nbrs;
  logic [lbp_pkg::CODE_W-1:0] code_d;
  logic [lbp_pkg::CODE_W-1:0] code_q;
  logic                       valid_q;

  assign nbrs = lbp_pkg::window_nbrs(win_i);

  // threshold every neighbour against the centre
  always_comb begin
    for (int i = 0; i < lbp_pkg::CODE_W; i++) begin
      code_d[i] = (nbrs[i] >= win_i.c);
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= win_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (win_valid_i) begin
      code_q <= code_d;
    end
  end

  assign req_o = '{valid: valid_q, code: code_q};

endmodule

`default_nettype wire

// ==== logic/hist_arbiter.sv ====
`default_nettype none

module hist_arbiter (
  input  logic                       clk,
  input  logic                       arst_n_i,
  input  lbp_pkg::code_req_t         ni_req_i,
  input  lbp_pkg::code_req_t         lbp_req_i,
  output logic                       inc_o,
  output lbp_pkg::desc_e             inc_desc_o,
  output logic [lbp_pkg::CODE_W-1:0] inc_code_o,
  output logic                       frame_done_o,
  input  logic                       valid_i
);

  logic                          pend_ni_q;
  logic                          pend_lbp_q;
  logic [lbp_pkg::CODE_W-1:0]    code_ni_q;
  logic [lbp_pkg::CODE_W-1:0]    code_lbp_q;
  logic                          grant_ni;
  logic                          grant_lbp;
  logic [lbp_pkg::PIX_CNT_W-1:0] pix_cnt_q;
  logic                          last_pix;
  logic [lbp_pkg::DONE_DLY-1:0]  done_sr_q;

  // fixed priority, NI first
  assign grant_ni  = pend_ni_q;
  assign grant_lbp = pend_lbp_q && !pend_ni_q;

  assign inc_o      = grant_ni || grant_lbp;
  assign inc_desc_o = grant_ni ? lbp_pkg::DESC_NI : lbp_pkg::DESC_LBP;
  assign inc_code_o = grant_ni ? code_ni_q : code_lbp_q;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pend_ni_q  <= 1'b0;
      pend_lbp_q <= 1'b0;
    end else begin
      pend_ni_q  <= (pend_ni_q && !grant_ni) || ni_req_i.valid;
      pend_lbp_q <= (pend_lbp_q && !grant_lbp) || lbp_req_i.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (ni_req_i.valid) begin
      code_ni_q <= ni_req_i.code;
    end
    if (lbp_req_i.valid) begin
      code_lbp_q <= lbp_req_i.code;
    end
  end

  // frame end, delayed past the last two increments
  assign last_pix = valid_i && (pix_cnt_q == lbp_pkg::PIX_CNT_W'(lbp_pkg::FRAME_PIX - 1));

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pix_cnt_q <= '0;
      done_sr_q <= '0;
    end else begin
      if (valid_i) begin
        pix_cnt_q <= last_pix ? '0 : pix_cnt_q + 1'b1;
      end
      done_sr_q <= {done_sr_q[lbp_pkg::DONE_DLY-2:0], last_pix};
    end
  end

  assign frame_done_o = done_sr_q[lbp_pkg::DONE_DLY-1];

  // input spacing keeps at most one code per unit in flight
  a_ni_no_overflow: assert property (@(posedge clk) disable iff (!arst_n_i)
    ni_req_i.valid |-> !pend_ni_q)
    else $error("hist_arbiter: NI request while NI still pending");

  a_lbp_no_overflow: assert property (@(posedge clk) disable iff (!arst_n_i)
    lbp_req_i.valid |-> !pend_lbp_q || grant_lbp)
    else $error("hist_arbiter: LBP request while LBP still pending");

endmodule

`default_nettype wire

// ==== logic/code_histogram.sv ====
`default_nettype none

module code_histogram (
  input  logic                       clk,
  input  logic                       arst_n_i,
  input  logic                       clear_i,
  input  logic                       inc_i,
  input  lbp_pkg::desc_e             inc_desc_i,
  input  logic [lbp_pkg::CODE_W-1:0] inc_code_i,
  input  lbp_pkg::desc_e             rd_desc_i,
  input  logic [lbp_pkg::CODE_W-1:0] rd_code_i,
  output logic [lbp_pkg::CNT_W-1:0]  rd_count_o
);

  // bank select in the top address bit
  logic [lbp_pkg::CNT_W-1:0] bins_q [lbp_pkg::NUM_BINS];
  logic [lbp_pkg::BIN_W-1:0] inc_addr;
  logic [lbp_pkg::BIN_W-1:0] rd_addr;
  logic                      inc_sat;

  assign inc_addr = {inc_desc_i, inc_code_i};
  assign rd_addr  = {rd_desc_i, rd_code_i};
  assign inc_sat  = (bins_q[inc_addr] == '1);

  // clear beats increment
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < lbp_pkg::NUM_BINS; i++) begin
        bins_q[i] <= '0;
      end
    end else if (clear_i) begin
      for (int i = 0; i < lbp_pkg::NUM_BINS; i++) begin
        bins_q[i] <= '0;
      end
    end else if (inc_i && !inc_sat) begin
      bins_q[inc_addr] <= bins_q[inc_addr] + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    rd_count_o <= bins_q[rd_addr];
  end

  // a bin only moves up unless cleared
  a_no_wrap: assert property (@(posedge clk) disable iff (!arst_n_i)
    inc_i && !clear_i |=> bins_q[$past(inc_addr)] >= $past(bins_q[inc_addr]))
    else $error("code_histogram: bin counter wrapped");

endmodule

`default_nettype wire

// ==== logic/lbp_texture_top.sv ====
`default_nettype none

module lbp_texture_top (
  input  logic                       clk,
  input  logic                       arst_n_i,
  input  logic                       valid_i,
  input  logic [lbp_pkg::PIX_W-1:0]  pixel_i,
  input  logic                       clear_i,
  input  lbp_pkg::desc_e             rd_desc_i,
  input  logic [lbp_pkg::CODE_W-1:0] rd_code_i,
  output logic [lbp_pkg::CNT_W-1:0]  rd_count_o,
  output logic                       frame_done_o
);

  logic                       win_valid;
  lbp_pkg::window_t           win;
  lbp_pkg::code_req_t         ni_req;
  lbp_pkg::code_req_t         lbp_req;
  logic                       inc;
  lbp_pkg::desc_e             inc_desc;
  logic [lbp_pkg::CODE_W-1:0] inc_code;

  line_window_3x3 line_window_3x3_inst (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .valid_i     (valid_i),
    .pixel_i     (pixel_i),
    .win_valid_o (win_valid),
    .win_o       (win)
  );

  // both code units see the same window
  ni_code ni_code_inst (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .win_valid_i (win_valid),
    .win_i       (win),
    .req_o       (ni_req)
  );

  lbp_code lbp_code_inst (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .win_valid_i (win_valid),
    .win_i       (win),
    .req_o       (lbp_req)
  );

  hist_arbiter hist_arbiter_inst (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .ni_req_i     (ni_req),
    .lbp_req_i    (lbp_req),
    .inc_o        (inc),
    .inc_desc_o   (inc_desc),
    .inc_code_o   (inc_code),
    .frame_done_o (frame_done_o),
    .valid_i      (valid_i)
  );

  code_histogram code_histogram_inst (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .clear_i    (clear_i),
    .inc_i      (inc),
    .inc_desc_i (inc_desc),
    .inc_code_i (inc_code),
    .rd_desc_i  (rd_desc_i),
    .rd_code_i  (rd_code_i),
    .rd_count_o (rd_count_o)
  );

endmodule

`default_nettype wire

// ==== verif/lbp_texture_model.svh ====
`ifndef LBP_TEXTURE_MODEL_SVH
`define LBP_TEXTURE_MODEL_SVH

// frame being streamed, indexed [row][col]
logic [lbp_pkg::PIX_W-1:0] frame_pix [lbp_pkg::IMG_ROWS][lbp_pkg::IMG_COLS];

// expected bins, one array per descriptor
int unsigned exp_ni_bins [1 << lbp_pkg::CODE_W];
int unsigned exp_lbp_bins [1 << lbp_pkg::CODE_W];

// neighbour of (r, c) for code bit b, in the order e, ne, n, nw, w, sw, s, se
function automatic int nbr_of(int r, int c, int b);
  int dr;
  int dc;
  dr = (b >= 1 && b <= 3) ? -1 : ((b >= 5) ? 1 : 0);
  dc = (b <= 1 || b == 7) ? 1 : ((b >= 3 && b <= 5) ? -1 : 0);
  return int'(frame_pix[r + dr][c + dc]);
endfunction

function automatic logic [lbp_pkg::CODE_W-1:0] ref_lbp_code(int r, int c);
  logic [lbp_pkg::CODE_W-1:0] code;
  for (int b = 0; b < lbp_pkg::CODE_W; b++) begin
    code[b] = (nbr_of(r, c, b) >= int'(frame_pix[r][c]));
  end
  return code;
endfunction

// neighbour at or above the window mean, kept in integers
function automatic logic [lbp_pkg::CODE_W-1:0] ref_ni_code(int r, int c);
  logic [lbp_pkg::CODE_W-1:0] code;
  int sum;
  sum = int'(frame_pix[r][c]);
  for (int b = 0; b < lbp_pkg::CODE_W; b++) begin
    sum = sum + nbr_of(r, c, b);
  end
  for (int b = 0; b < lbp_pkg::CODE_W; b++) begin
    code[b] = (9 * nbr_of(r, c, b) >= sum);
  end
  return code;
endfunction

// interior centres only, border pixels have no full window
function automatic void model_add_frame();
  for (int r = 1; r < lbp_pkg::IMG_ROWS - 1; r++) begin
    for (int c = 1; c < lbp_pkg::IMG_COLS - 1; c++) begin
      exp_ni_bins[ref_ni_code(r, c)]++;
      exp_lbp_bins[ref_lbp_code(r, c)]++;
    end
  end
endfunction

function automatic void model_clear();
  for (int i = 0; i < (1 << lbp_pkg::CODE_W); i++) begin
    exp_ni_bins[i] = 0;
    exp_lbp_bins[i] = 0;
  end
endfunction

`endif

// ==== verif/lbp_texture_tb.sv ====
`default_nettype none

module lbp_texture_tb;
  timeunit 1ns;
  timeprecision 100ps;

  // three frames at 4 cycles per pixel, readouts and margin
  localparam int TIMEOUT_CYCLES = 12000;
  localparam int WINDOWS = (lbp_pkg::IMG_ROWS - 2) * (lbp_pkg::IMG_COLS - 2);
  localparam int NBINS = 1 << lbp_pkg::CODE_W;
  localparam int DONE_LAT = 5;

  logic                       clk;
  logic                       arst_n_i;
  logic                       valid_i;
  logic [lbp_pkg::PIX_W-1:0]  pixel_i;
  logic                       clear_i;
  lbp_pkg::desc_e             rd_desc_i;
  logic [lbp_pkg::CODE_W-1:0] rd_code_i;
  logic [lbp_pkg::CNT_W-1:0]  rd_count_o;
  logic                       frame_done_o;

  integer                seed;
  int unsigned           cycle_cnt = 0;
  int unsigned           pix_seen_q;
  logic [DONE_LAT-1:0]   done_exp_q;
  int unsigned           frames_since_clear;

  `include "lbp_texture_model.svh"

  lbp_texture_top lbp_texture_top_inst (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .valid_i      (valid_i),
    .pixel_i      (pixel_i),
    .clear_i      (clear_i),
    .rd_desc_i    (rd_desc_i),
    .rd_code_i    (rd_code_i),
    .rd_count_o   (rd_count_o),
    .frame_done_o (frame_done_o)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("*** TEST FAILED ***");
      $fatal(1, "timeout");
    end
  end

  // expected frame_done_o, delayed from the frame's last pixel
  always @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pix_seen_q <= 0;
      done_exp_q <= '0;
    end else begin
      done_exp_q <= {done_exp_q[DONE_LAT-2:0],
                     valid_i && (pix_seen_q == lbp_pkg::FRAME_PIX - 1)};
      if (valid_i) begin
        pix_seen_q <= (pix_seen_q == lbp_pkg::FRAME_PIX - 1) ? 0 : pix_seen_q + 1;
      end
    end
  end

  a_done_timing: assert property (@(posedge clk) disable iff (!arst_n_i)
    frame_done_o == done_exp_q[DONE_LAT-1])
    else begin
      $display("[ERROR] frame_done_o got %h expected %h",
               $sampled(frame_done_o), $sampled(done_exp_q[DONE_LAT-1]));
      $display("*** TEST FAILED ***");
      $fatal(1, "frame_done_o timing");
    end

  task automatic expect_equal(input string name, input int unsigned got,
                              input int unsigned exp);
    assert (got == exp)
      else begin
        $display("[ERROR] %s got %h expected %h", name, got, exp);
        $display("*** TEST FAILED ***");
        $fatal(1, "value mismatch");
      end
  endtask

  // registered read, result is stable at the next falling edge
  task automatic read_bin(input lbp_pkg::desc_e desc, input int code,
                          output int unsigned count);
    rd_desc_i = desc;
    rd_code_i = lbp_pkg::CODE_W'(code);
    @(negedge clk);
    count = rd_count_o;
  endtask

  task automatic check_all_bins();
    int unsigned ni_got [NBINS];
    int unsigned lbp_got [NBINS];
    int unsigned ni_sum;
    int unsigned lbp_sum;
    ni_sum = 0;
    lbp_sum = 0;
    for (int code = 0; code < NBINS; code++) begin
      read_bin(lbp_pkg::DESC_NI, code, ni_got[code]);
      read_bin(lbp_pkg::DESC_LBP, code, lbp_got[code]);
      ni_sum += ni_got[code];
      lbp_sum += lbp_got[code];
    end
    // totals per descriptor, then bin by bin
    expect_equal("ni bin sum", ni_sum, WINDOWS * frames_since_clear);
    expect_equal("lbp bin sum", lbp_sum, WINDOWS * frames_since_clear);
    for (int code = 0; code < NBINS; code++) begin
      expect_equal($sformatf("rd_count_o (ni, %02h)", code), ni_got[code],
                   exp_ni_bins[code]);
      expect_equal($sformatf("rd_count_o (lbp, %02h)", code), lbp_got[code],
                   exp_lbp_bins[code]);
    end
  endtask

  // every window of a flat frame lands in bin ff
  task automatic check_flat_peak();
    int unsigned count;
    read_bin(lbp_pkg::DESC_NI, NBINS - 1, count);
    expect_equal("rd_count_o (ni, ff)", count, WINDOWS);
    read_bin(lbp_pkg::DESC_LBP, NBINS - 1, count);
    expect_equal("rd_count_o (lbp, ff)", count, WINDOWS);
  endtask

  function automatic void load_frame(input logic flat);
    logic [lbp_pkg::PIX_W-1:0] level;
    level = lbp_pkg::PIX_W'($random(seed));
    for (int r = 0; r < lbp_pkg::IMG_ROWS; r++) begin
      for (int c = 0; c < lbp_pkg::IMG_COLS; c++) begin
        frame_pix[r][c] = flat ? level : lbp_pkg::PIX_W'($random(seed));
      end
    end
  endfunction

  // raster order, 2 to 4 cycles per pixel
  task automatic stream_frame();
    int gap;
    for (int r = 0; r < lbp_pkg::IMG_ROWS; r++) begin
      for (int c = 0; c < lbp_pkg::IMG_COLS; c++) begin
        valid_i = 1'b1;
        pixel_i = frame_pix[r][c];
        @(negedge clk);
        valid_i = 1'b0;
        gap = 2 + int'($unsigned($random(seed)) % 3);
        repeat (gap - 1) @(negedge clk);
      end
    end
    while (!frame_done_o) @(negedge clk);
    frames_since_clear++;
    model_add_frame();
  endtask

  task automatic pulse_clear();
    clear_i = 1'b1;
    @(negedge clk);
    clear_i = 1'b0;
    frames_since_clear = 0;
    model_clear();
  endtask

  initial begin
    seed = 32164;
    clk = 1'b0;
    arst_n_i = 1'b0;
    valid_i = 1'b0;
    pixel_i = '0;
    clear_i = 1'b0;
    rd_desc_i = lbp_pkg::DESC_NI;
    rd_code_i = '0;
    frames_since_clear = 0;
    model_clear();
    repeat (5) @(posedge clk);
    @(negedge clk);
    arst_n_i = 1'b1;

    expect_equal("frame_done_o", frame_done_o, 0);
    check_all_bins();

    // flat frame, every comparison ties so both codes are ff
    load_frame(1'b1);
    stream_frame();
    check_flat_peak();
    check_all_bins();
    pulse_clear();
    check_all_bins();

    load_frame(1'b0);
    stream_frame();
    check_all_bins();

    // second frame accumulates on top of the first
    load_frame(1'b0);
    stream_frame();
    check_all_bins();
    pulse_clear();
    check_all_bins();

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

// ==== lbp_texture.f ====
+incdir+verif
logic/lbp_pkg.sv
logic/line_window_3x3.sv
logic/ni_code.sv
logic/lbp_code.sv
logic/hist_arbiter.sv
logic/code_histogram.sv
logic/lbp_texture_top.sv
verif/lbp_texture_tb.sv

// ==== Makefile ====
TOP = lbp_texture_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f lbp_texture.f -o V$(TOP)

# pass only if the simulation printed the pass line
run: compile
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir
